// ==== ahbSwitch_config.svh ====
`ifndef AHB_SWITCH_CONFIG_SVH
`define AHB_SWITCH_CONFIG_SVH

////////////////////////////////////////
// Bus widths
////////////////////////////////////////
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

// Switch dimensions
`define AHB_MASTERS 2
`define AHB_SLAVES  2

////////////////////////////////////////
// Address map
////////////////////////////////////////
// Only the top nibble takes part in the decode
`define SLV0_BASE 32'h0000_0000
`define SLV0_MASK 32'hF000_0000
`define SLV1_BASE 32'h1000_0000
`define SLV1_MASK 32'hF000_0000

`endif

// ==== ahbSwitchPkg.sv ====
`default_nettype none

`include "ahbSwitch_config.svh"

package ahbSwitchPkg;

  // HTRANS encoding as seen on every AHB-Lite port
  typedef enum logic [1:0] {
    htransIdle   = 2'b00,
    htransBusy   = 2'b01,
    htransNonseq = 2'b10,
    htransSeq    = 2'b11
  } htransT;

  // HRESP, single bit in AHB3-Lite
  typedef enum logic {
    hrespOkay  = 1'b0,
    hrespError = 1'b1
  } hrespT;

  // Port indices
  typedef logic [$clog2(`AHB_MASTERS)-1:0] mstIdxT;
  typedef logic [$clog2(`AHB_SLAVES)-1:0]  slvIdxT;

endpackage

`default_nettype wire

// ==== ahbMasterPort.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahbSwitch_config.svh"

module ahbMasterPort
  import ahbSwitchPkg::*;
(
  input  wire                     HCLK,
  input  wire                     rstN,

  // AHB-Lite master side
  input  wire  [`AHB_ADDR_W-1:0]  mstHaddr,
  input  wire                     mstHwrite,
  input  wire  [2:0]              mstHsize,
  input  var   htransT            mstHtrans,
  input  wire  [`AHB_DATA_W-1:0]  mstHwdata,
  output logic [`AHB_DATA_W-1:0]  mstHrdata,
  output logic                    mstHreadyout,
  output hrespT                   mstHresp,

  // Request towards the slave ports
  output logic [`AHB_SLAVES-1:0]  slvReq,
  output logic [`AHB_ADDR_W-1:0]  reqHaddr,
  output logic                    reqHwrite,
  output logic [2:0]              reqHsize,
  output htransT                  reqHtrans,
  output logic [`AHB_DATA_W-1:0]  reqHwdata,

  // Returns from the slave ports
  input  wire                     accept,
  input  wire  [`AHB_DATA_W-1:0]  fwdHrdata    [`AHB_SLAVES],
  input  wire                     fwdHreadyout [`AHB_SLAVES],
  input  var   hrespT             fwdHresp     [`AHB_SLAVES]
);

  // Region table, one entry per slave
  localparam logic [`AHB_ADDR_W-1:0] slvBase [`AHB_SLAVES] = '{`SLV0_BASE, `SLV1_BASE};
  localparam logic [`AHB_ADDR_W-1:0] slvMask [`AHB_SLAVES] = '{`SLV0_MASK, `SLV1_MASK};

  // Address phase waiting for a slave port
  logic                   holdValid;
  logic                   holdLoad;
  logic [`AHB_ADDR_W-1:0] holdHaddr;
  logic                   holdHwrite;
  logic [2:0]             holdHsize;
  htransT                 holdHtrans;

  // Data phase owner and error sequencer
  logic                   dpValid;
  slvIdxT                 dpSlv;
  logic                   errFirst;
  logic                   errSecond;

  // Decode of the presented address phase
  logic                   liveValid;
  logic                   reqValid;
  logic                   decHit;
  slvIdxT                 decSlv;

  ////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////

  // Live phase only counts when the master sees HREADY high
  assign liveValid = mstHreadyout &&
                     (mstHtrans == htransNonseq || mstHtrans == htransSeq);
  assign reqValid  = holdValid || liveValid;

  // Held values win while a request is pending
  always_comb
  begin
    if (holdValid)
    begin
      reqHaddr  = holdHaddr;
      reqHwrite = holdHwrite;
      reqHsize  = holdHsize;
      reqHtrans = holdHtrans;
    end
    else
    begin
      reqHaddr  = mstHaddr;
      reqHwrite = mstHwrite;
      reqHsize  = mstHsize;
      reqHtrans = mstHtrans;
    end
  end

  // Base/mask match, last region hit takes it
  always_comb
  begin
    decHit = 1'b0;
    decSlv = '0;
    for (int s = 0; s < `AHB_SLAVES; s++)
    begin
      if ((reqHaddr & slvMask[s]) == (slvBase[s] & slvMask[s]))
      begin
        decHit = 1'b1;
        decSlv = slvIdxT'(s);
      end
    end
  end

  // One request line per slave
  always_comb
  begin
    slvReq = '0;
    if (reqValid && decHit)
      slvReq[decSlv] = 1'b1;
  end

  // Master owns HWDATA during its data phase, slave port picks it up
  assign reqHwdata = mstHwdata;

  // Capture when the slave port could not take the live phase
  assign holdLoad = liveValid && decHit && !accept;

  always_ff @(posedge HCLK)
  begin
    if (holdLoad)
    begin
      holdHaddr  <= mstHaddr;
      holdHwrite <= mstHwrite;
      holdHsize  <= mstHsize;
      holdHtrans <= mstHtrans;
    end
  end

  ////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////
  always_ff @(posedge HCLK)
  begin
    if (!rstN)
    begin
      holdValid <= 1'b0;
      dpValid   <= 1'b0;
      dpSlv     <= '0;
      errFirst  <= 1'b0;
      errSecond <= 1'b0;
    end
    else
    begin
      // Pending request leaves on accept
      holdValid <= holdValid ? !accept : holdLoad;

      // Accepted phase moves into the data phase, HREADY high closes it
      if (accept)
      begin
        dpValid <= 1'b1;
        dpSlv   <= decSlv;
      end
      else if (mstHreadyout)
        dpValid <= 1'b0;

      // Unmapped address gets the two-cycle ERROR
      errFirst  <= liveValid && !decHit;
      errSecond <= errFirst;
    end
  end

  // Return path, muxed by the data-phase slave
  always_comb
  begin
    mstHrdata = fwdHrdata[dpSlv];
    if (errFirst)
    begin
      mstHreadyout = 1'b0;
      mstHresp     = hrespError;
    end
    else if (errSecond)
    begin
      mstHreadyout = 1'b1;
      mstHresp     = hrespError;
    end
    else if (holdValid)
    begin
      // Stall the master until a slave port takes it
      mstHreadyout = 1'b0;
      mstHresp     = hrespOkay;
    end
    else if (dpValid)
    begin
      mstHreadyout = fwdHreadyout[dpSlv];
      mstHresp     = fwdHresp[dpSlv];
    end
    else
    begin
      mstHreadyout = 1'b1;
      mstHresp     = hrespOkay;
    end
  end

endmodule

`default_nettype wire

// ==== ahbSlavePort.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahbSwitch_config.svh"

module ahbSlavePort
  import ahbSwitchPkg::*;
(
  input  wire                     HCLK,
  input  wire                     rstN,

  // Requests from the master ports
  input  wire  [`AHB_MASTERS-1:0] slvReq,
  input  wire  [`AHB_ADDR_W-1:0]  reqHaddr  [`AHB_MASTERS],
  input  wire                     reqHwrite [`AHB_MASTERS],
  input  wire  [2:0]              reqHsize  [`AHB_MASTERS],
  input  var   htransT            reqHtrans [`AHB_MASTERS],
  input  wire  [`AHB_DATA_W-1:0]  mstHwdata [`AHB_MASTERS],

  // Towards the master ports
  output logic [`AHB_MASTERS-1:0] accept,
  output logic [`AHB_DATA_W-1:0]  fwdHrdata,
  output logic                    fwdHreadyout,
  output hrespT                   fwdHresp,

  // AHB-Lite slave side
  output logic                    slvHsel,
  output logic [`AHB_ADDR_W-1:0]  slvHaddr,
  output logic                    slvHwrite,
  output logic [2:0]              slvHsize,
  output htransT                  slvHtrans,
  output logic [`AHB_DATA_W-1:0]  slvHwdata,
  input  wire  [`AHB_DATA_W-1:0]  slvHrdata,
  input  wire                     slvHreadyout,
  input  var   hrespT             slvHresp
);

  // Arbitration result
  logic   grantValid;
  mstIdxT grantIdx;

  // Master that holds the data phase
  logic   ownerValid;
  mstIdxT ownerIdx;

  ////////////////////////////////////////
  // Arbiter
  ////////////////////////////////////////

  // Fixed order, scanned downwards so master 0 ends up on top
  always_comb
  begin
    grantValid = 1'b0;
    grantIdx   = '0;
    for (int m = `AHB_MASTERS - 1; m >= 0; m--)
    begin
      if (slvReq[m])
      begin
        grantValid = 1'b1;
        grantIdx   = mstIdxT'(m);
      end
    end
  end

  // Taken only when the slave is ready, losers stay held in their port
  always_comb
  begin
    accept = '0;
    if (grantValid && slvHreadyout)
      accept[grantIdx] = 1'b1;
  end

  ////////////////////////////////////////
  // Address phase mux
  ////////////////////////////////////////
  always_comb
  begin
    if (grantValid)
    begin
      slvHsel   = 1'b1;
      slvHaddr  = reqHaddr[grantIdx];
      slvHwrite = reqHwrite[grantIdx];
      slvHsize  = reqHsize[grantIdx];
      slvHtrans = reqHtrans[grantIdx];
    end
    else
    begin
      // Nobody asking, park the bus idle
      slvHsel   = 1'b0;
      slvHaddr  = '0;
      slvHwrite = 1'b0;
      slvHsize  = '0;
      slvHtrans = htransIdle;
    end
  end

  ////////////////////////////////////////
  // Data phase
  ////////////////////////////////////////

  // Owner advances together with the slave pipeline
  always_ff @(posedge HCLK)
  begin
    if (!rstN)
    begin
      ownerValid <= 1'b0;
      ownerIdx   <= '0;
    end
    else if (slvHreadyout)
    begin
      ownerValid <= grantValid;
      ownerIdx   <= grantIdx;
    end
  end

  // Write data follows the owner, zero when no data phase runs
  assign slvHwdata = ownerValid ? mstHwdata[ownerIdx] : '0;

  // Slave returns go to every master port, each one picks its own
  assign fwdHrdata    = slvHrdata;
  assign fwdHreadyout = slvHreadyout;
  assign fwdHresp     = slvHresp;

endmodule

`default_nettype wire

// ==== ahbSwitchTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahbSwitch_config.svh"

module ahbSwitchTop
  import ahbSwitchPkg::*;
(
  input  wire                     HCLK,
  input  wire                     rstN,

  // Master side, one entry per AHB master
  input  wire  [`AHB_ADDR_W-1:0]  mstHaddr     [`AHB_MASTERS],
  input  wire                     mstHwrite    [`AHB_MASTERS],
  input  wire  [2:0]              mstHsize     [`AHB_MASTERS],
  input  var   htransT            mstHtrans    [`AHB_MASTERS],
  input  wire  [`AHB_DATA_W-1:0]  mstHwdata    [`AHB_MASTERS],
  output logic [`AHB_DATA_W-1:0]  mstHrdata    [`AHB_MASTERS],
  output logic                    mstHreadyout [`AHB_MASTERS],
  output hrespT                   mstHresp     [`AHB_MASTERS],

  // Slave side, one entry per AHB slave
  output logic                    slvHsel      [`AHB_SLAVES],
  output logic [`AHB_ADDR_W-1:0]  slvHaddr     [`AHB_SLAVES],
  output logic                    slvHwrite    [`AHB_SLAVES],
  output logic [2:0]              slvHsize     [`AHB_SLAVES],
  output htransT                  slvHtrans    [`AHB_SLAVES],
  output logic [`AHB_DATA_W-1:0]  slvHwdata    [`AHB_SLAVES],
  input  wire  [`AHB_DATA_W-1:0]  slvHrdata    [`AHB_SLAVES],
  input  wire                     slvHreadyout [`AHB_SLAVES],
  input  var   hrespT             slvHresp     [`AHB_SLAVES]
);

  // Master port outputs
  logic [`AHB_SLAVES-1:0]  mstReq      [`AHB_MASTERS];
  logic [`AHB_ADDR_W-1:0]  reqHaddr    [`AHB_MASTERS];
  logic                    reqHwrite   [`AHB_MASTERS];
  logic [2:0]              reqHsize    [`AHB_MASTERS];
  htransT                  reqHtrans   [`AHB_MASTERS];
  logic [`AHB_DATA_W-1:0]  reqHwdata   [`AHB_MASTERS];
  logic [`AHB_SLAVES-1:0]  acceptBySlv [`AHB_MASTERS];
  logic                    mstAccept   [`AHB_MASTERS];

  // Slave port outputs
  logic [`AHB_MASTERS-1:0] slvReq       [`AHB_SLAVES];
  logic [`AHB_MASTERS-1:0] slvAccept    [`AHB_SLAVES];
  logic [`AHB_DATA_W-1:0]  fwdHrdata    [`AHB_SLAVES];
  logic                    fwdHreadyout [`AHB_SLAVES];
  hrespT                   fwdHresp     [`AHB_SLAVES];

  ////////////////////////////////////////
  // Master ports
  ////////////////////////////////////////
  for (genvar m = 0; m < `AHB_MASTERS; m++)
  begin : genMasterPort
    ahbMasterPort masterPort (
      .HCLK         (HCLK),
      .rstN         (rstN),
      .mstHaddr     (mstHaddr[m]),
      .mstHwrite    (mstHwrite[m]),
      .mstHsize     (mstHsize[m]),
      .mstHtrans    (mstHtrans[m]),
      .mstHwdata    (mstHwdata[m]),
      .mstHrdata    (mstHrdata[m]),
      .mstHreadyout (mstHreadyout[m]),
      .mstHresp     (mstHresp[m]),
      .slvReq       (mstReq[m]),
      .reqHaddr     (reqHaddr[m]),
      .reqHwrite    (reqHwrite[m]),
      .reqHsize     (reqHsize[m]),
      .reqHtrans    (reqHtrans[m]),
      .reqHwdata    (reqHwdata[m]),
      .accept       (mstAccept[m]),
      .fwdHrdata    (fwdHrdata),
      .fwdHreadyout (fwdHreadyout),
      .fwdHresp     (fwdHresp)
    );

    // A master requests one slave at a time, so at most one accept is set
    assign mstAccept[m] = |acceptBySlv[m];
  end

  ////////////////////////////////////////
  // Request and accept transpose
  ////////////////////////////////////////
  for (genvar s = 0; s < `AHB_SLAVES; s++)
  begin : genCross
    for (genvar m = 0; m < `AHB_MASTERS; m++)
    begin : genBit
      assign slvReq[s][m]      = mstReq[m][s];
      assign acceptBySlv[m][s] = slvAccept[s][m];
    end
  end

  ////////////////////////////////////////
  // Slave ports
  ////////////////////////////////////////
  for (genvar s = 0; s < `AHB_SLAVES; s++)
  begin : genSlavePort
    ahbSlavePort slavePort (
      .HCLK         (HCLK),
      .rstN         (rstN),
      .slvReq       (slvReq[s]),
      .reqHaddr     (reqHaddr),
      .reqHwrite    (reqHwrite),
      .reqHsize     (reqHsize),
      .reqHtrans    (reqHtrans),
      .mstHwdata    (reqHwdata),
      .accept       (slvAccept[s]),
      .fwdHrdata    (fwdHrdata[s]),
      .fwdHreadyout (fwdHreadyout[s]),
      .fwdHresp     (fwdHresp[s]),
      .slvHsel      (slvHsel[s]),
      .slvHaddr     (slvHaddr[s]),
      .slvHwrite    (slvHwrite[s]),
      .slvHsize     (slvHsize[s]),
      .slvHtrans    (slvHtrans[s]),
      .slvHwdata    (slvHwdata[s]),
      .slvHrdata    (slvHrdata[s]),
      .slvHreadyout (slvHreadyout[s]),
      .slvHresp     (slvHresp[s])
    );
  end

endmodule

`default_nettype wire

// ==== tbMemSlave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahbSwitch_config.svh"

module tbMemSlave
  import ahbSwitchPkg::*;
(
  input  wire                     HCLK,
  input  wire                     rstN,
  input  wire  [3:0]              waitStates,
  input  wire                     hsel,
  input  wire  [`AHB_ADDR_W-1:0]  haddr,
  input  wire                     hwrite,
  input  wire  [2:0]              hsize,
  input  var   htransT            htrans,
  input  wire  [`AHB_DATA_W-1:0]  hwdata,
  output logic [`AHB_DATA_W-1:0]  hrdata,
  output logic                    hreadyout,
  output hrespT                   hresp
);

  // 1024 words, word accesses only, so hsize is ignored
  logic [`AHB_DATA_W-1:0] mem [1024];

  // Data phase state
  logic       dpActive;
  logic       dpWrite;
  logic [9:0] dpIndex;
  logic [3:0] waitCnt;

  // Fill pattern spreads every index bit over the word
  initial
  begin
    for (logic [10:0] i = 0; i < 11'd1024; i++)
      mem[i[9:0]] = 32'hC0DE_0000 ^ ({22'b0, i[9:0]} * 32'h9E37_79B9);
  end

  // Low while wait states remain
  assign hreadyout = !(dpActive && waitCnt != 4'd0);
  assign hresp     = hrespOkay;
  assign hrdata    = (dpActive && !dpWrite) ? mem[dpIndex] : '0;

  always_ff @(posedge HCLK)
  begin
    if (!rstN)
    begin
      dpActive <= 1'b0;
      dpWrite  <= 1'b0;
      dpIndex  <= '0;
      waitCnt  <= '0;
    end
    else if (hreadyout)
    begin
      // Next address phase is sampled as the current data phase ends
      dpActive <= hsel && (htrans == htransNonseq || htrans == htransSeq);
      dpWrite  <= hwrite;
      dpIndex  <= haddr[11:2];
      waitCnt  <= waitStates;
    end
    else
      waitCnt <= waitCnt - 4'd1;
  end

  // Write lands on the last data-phase edge
  always @(posedge HCLK)
  begin
    if (rstN && dpActive && dpWrite && hreadyout)
      mem[dpIndex] <= hwdata;
  end

endmodule

`default_nettype wire

// ==== tbAhbSwitch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ahbSwitch_config.svh"

module tbAhbSwitch
  import ahbSwitchPkg::*;
();

  // 2 x 150 random transfers of at most 8 cycles each plus the directed tests and a margin
  localparam int maxCycles = 3000;

  logic HCLK;
  logic rstN;

  // Master side
  logic [`AHB_ADDR_W-1:0] mstHaddr     [`AHB_MASTERS];
  logic                   mstHwrite    [`AHB_MASTERS];
  logic [2:0]             mstHsize     [`AHB_MASTERS];
  htransT                 mstHtrans    [`AHB_MASTERS];
  logic [`AHB_DATA_W-1:0] mstHwdata    [`AHB_MASTERS];
  logic [`AHB_DATA_W-1:0] mstHrdata    [`AHB_MASTERS];
  logic                   mstHreadyout [`AHB_MASTERS];
  hrespT                  mstHresp     [`AHB_MASTERS];

  // Slave side
  logic                   slvHsel      [`AHB_SLAVES];
  logic [`AHB_ADDR_W-1:0] slvHaddr     [`AHB_SLAVES];
  logic                   slvHwrite    [`AHB_SLAVES];
  logic [2:0]             slvHsize     [`AHB_SLAVES];
  htransT                 slvHtrans    [`AHB_SLAVES];
  logic [`AHB_DATA_W-1:0] slvHwdata    [`AHB_SLAVES];
  logic [`AHB_DATA_W-1:0] slvHrdata    [`AHB_SLAVES];
  logic                   slvHreadyout [`AHB_SLAVES];
  hrespT                  slvHresp     [`AHB_SLAVES];

  // Scoreboard with one 32-word window per master
  logic [`AHB_DATA_W-1:0] expData  [`AHB_MASTERS][32];
  bit                     expValid [`AHB_MASTERS][32];

  integer seed;
  int     errorCount = 0;
  int     checkCount = 0;
  int     passCount = 0;
  int     failCount = 0;
  int     errorsAtStart = 0;
  int     cycleCount = 0;
  string  testName;

  ahbSwitchTop i_dut (
    .HCLK         (HCLK),
    .rstN         (rstN),
    .mstHaddr     (mstHaddr),
    .mstHwrite    (mstHwrite),
    .mstHsize     (mstHsize),
    .mstHtrans    (mstHtrans),
    .mstHwdata    (mstHwdata),
    .mstHrdata    (mstHrdata),
    .mstHreadyout (mstHreadyout),
    .mstHresp     (mstHresp),
    .slvHsel      (slvHsel),
    .slvHaddr     (slvHaddr),
    .slvHwrite    (slvHwrite),
    .slvHsize     (slvHsize),
    .slvHtrans    (slvHtrans),
    .slvHwdata    (slvHwdata),
    .slvHrdata    (slvHrdata),
    .slvHreadyout (slvHreadyout),
    .slvHresp     (slvHresp)
  );

  // Slave s inserts s wait states
  for (genvar s = 0; s < `AHB_SLAVES; s++)
  begin : genMem
    tbMemSlave memSlave (
      .HCLK       (HCLK),
      .rstN       (rstN),
      .waitStates (4'(s)),
      .hsel       (slvHsel[s]),
      .haddr      (slvHaddr[s]),
      .hwrite     (slvHwrite[s]),
      .hsize      (slvHsize[s]),
      .htrans     (slvHtrans[s]),
      .hwdata     (slvHwdata[s]),
      .hrdata     (slvHrdata[s]),
      .hreadyout  (slvHreadyout[s]),
      .hresp      (slvHresp[s])
    );
  end

  initial
  begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  // Watchdog
  initial
  begin
    while (cycleCount < maxCycles)
    begin
      @(posedge HCLK);
      cycleCount++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", maxCycles);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////
  // Checks and bookkeeping
  ////////////////////////////////////////
  task automatic checkValue(input string name, input logic [`AHB_DATA_W-1:0] expected,
                            input logic [`AHB_DATA_W-1:0] actual);
    checkCount++;
    assert (actual === expected)
    else
    begin
      errorCount++;
      $display("FAILED %s: expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  task automatic checkTrue(input bit ok, input string what);
    checkCount++;
    assert (ok)
    else
    begin
      errorCount++;
      $display("ERROR: %s", what);
    end
  endtask

  task automatic beginTest(input string name);
    testName      = name;
    errorsAtStart = errorCount;
  endtask

  task automatic endTest();
    if (errorCount == errorsAtStart)
    begin
      passCount++;
      $display("PASS %s", testName);
    end
    else
    begin
      failCount++;
      $display("FAIL %s", testName);
    end
  endtask

  // Every transfer is a word transfer, so each address phase on a slave carries size 2
  always @(negedge HCLK)
  begin
    for (int s = 0; s < `AHB_SLAVES; s++)
    begin
      if (rstN && slvHsel[s] && slvHtrans[s] == htransNonseq)
        checkValue($sformatf("slvHsize[%0d]", s), 32'd2, 32'(slvHsize[s]));
    end
  end

  ////////////////////////////////////////
  // Master transfer tasks
  ////////////////////////////////////////

  // Single transfer entered and left 1 ns after a rising edge
  // cycles counts from the address phase up to the end of the data phase
  task automatic runTransfer(input mstIdxT m, input logic [`AHB_ADDR_W-1:0] addr,
                             input logic write, input logic [`AHB_DATA_W-1:0] wdata,
                             output logic [`AHB_DATA_W-1:0] rdata, output hrespT resp,
                             output int cycles);
    cycles       = 0;
    mstHaddr[m]  = addr;
    mstHwrite[m] = write;
    mstHsize[m]  = 3'b010;
    mstHtrans[m] = htransNonseq;
    // Address phase ends on the edge after HREADY is seen high
    do
    begin
      @(negedge HCLK);
      cycles++;
    end while (!mstHreadyout[m]);
    @(posedge HCLK);
    #1;
    // Address signals are free once the address phase is over
    mstHtrans[m] = htransIdle;
    mstHaddr[m]  = ~addr;
    mstHwrite[m] = !write;
    mstHsize[m]  = 3'b000;
    if (write)
      mstHwdata[m] = wdata;
    // Data phase
    do
    begin
      @(negedge HCLK);
      cycles++;
    end while (!mstHreadyout[m]);
    rdata = mstHrdata[m];
    resp  = mstHresp[m];
    @(posedge HCLK);
    #1;
  endtask

  // Transfer expected to be OKAY with a known length and reads compared with data
  task automatic checkedTransfer(input mstIdxT m, input logic [`AHB_ADDR_W-1:0] addr,
                                 input logic write, input logic [`AHB_DATA_W-1:0] data,
                                 input int expCycles);
    logic [`AHB_DATA_W-1:0] rdata;
    hrespT                  resp;
    int                     cycles;
    runTransfer(m, addr, write, data, rdata, resp, cycles);
    checkValue($sformatf("mstHresp[%0d]", m), 32'(hrespOkay), 32'(resp));
    checkTrue(cycles == expCycles, $sformatf("master %0d took %0d cycles instead of %0d",
                                             m, cycles, expCycles));
    if (!write)
      checkValue($sformatf("mstHrdata[%0d]", m), data, rdata);
  endtask

  // 16 words per region with master 0 at offset 0x100 and master 1 at 0x200
  function automatic logic [`AHB_ADDR_W-1:0] windowAddr(input mstIdxT m,
                                                        input logic [4:0] slot);
    windowAddr = (32'(slot[4]) << 28) | ((32'(m) + 32'd1) << 8) | (32'(slot[3:0]) << 2);
  endfunction

  task automatic randomTraffic(input mstIdxT m);
    logic [1:0]             idle;
    logic [4:0]             slot;
    logic                   write;
    logic [`AHB_DATA_W-1:0] data;
    logic [`AHB_DATA_W-1:0] rdata;
    hrespT                  resp;
    int                     cycles;
    for (int n = 0; n < 150; n++)
    begin
      idle  = 2'($random(seed));
      slot  = 5'($random(seed));
      data  = $random(seed);
      // Reads only go to words this master wrote before
      write = !expValid[m][slot] || 1'($random(seed));
      repeat (idle)
      begin
        @(posedge HCLK);
        #1;
      end
      runTransfer(m, windowAddr(m, slot), write, data, rdata, resp, cycles);
      checkValue($sformatf("mstHresp[%0d]", m), 32'(hrespOkay), 32'(resp));
      if (write)
      begin
        expData[m][slot]  = data;
        expValid[m][slot] = 1'b1;
      end
      else
        checkValue($sformatf("mstHrdata[%0d]", m), expData[m][slot], rdata);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial
  begin
    logic [`AHB_DATA_W-1:0] rdata;
    hrespT                  resp;
    int                     cycles;
    seed      = 32'h4c0e_b98d;
    rstN      = 1'b0;
    mstHaddr  = '{default: '0};
    mstHwrite = '{default: 1'b0};
    mstHsize  = '{default: 3'b010};
    mstHtrans = '{default: htransIdle};
    mstHwdata = '{default: '0};
    repeat (2) @(posedge HCLK);
    #1;
    rstN = 1'b1;

    beginTest("reset values");
    @(negedge HCLK);
    checkValue("mstHreadyout[0]", 32'd1, 32'(mstHreadyout[0]));
    checkValue("mstHreadyout[1]", 32'd1, 32'(mstHreadyout[1]));
    checkValue("mstHresp[0]", 32'(hrespOkay), 32'(mstHresp[0]));
    checkValue("mstHresp[1]", 32'(hrespOkay), 32'(mstHresp[1]));
    checkValue("slvHsel[0]", 32'd0, 32'(slvHsel[0]));
    checkValue("slvHsel[1]", 32'd0, 32'(slvHsel[1]));
    checkValue("slvHtrans[0]", 32'(htransIdle), 32'(slvHtrans[0]));
    checkValue("slvHtrans[1]", 32'(htransIdle), 32'(slvHtrans[1]));
    @(posedge HCLK);
    #1;
    endTest();

    // Slave 1 adds its one wait state
    beginTest("single master access");
    checkedTransfer(1'b0, 32'h0000_0010, 1'b1, 32'h1234_5678, 2);
    checkedTransfer(1'b0, 32'h0000_0010, 1'b0, 32'h1234_5678, 2);
    checkedTransfer(1'b0, 32'h1000_0010, 1'b1, 32'h9ABC_DEF0, 3);
    checkedTransfer(1'b0, 32'h1000_0010, 1'b0, 32'h9ABC_DEF0, 3);
    endTest();

    beginTest("parallel access");
    fork
      checkedTransfer(1'b0, 32'h0000_0020, 1'b1, 32'h0BAD_F00D, 2);
      checkedTransfer(1'b1, 32'h1000_0020, 1'b1, 32'h5EED_CAFE, 3);
    join
    fork
      checkedTransfer(1'b0, 32'h0000_0020, 1'b0, 32'h0BAD_F00D, 2);
      checkedTransfer(1'b1, 32'h1000_0020, 1'b0, 32'h5EED_CAFE, 3);
    join
    endTest();

    beginTest("contention on slave 0");
    fork
      checkedTransfer(1'b0, 32'h0000_0040, 1'b1, 32'hC0FF_EE00, 2);
      // Loses to master 0 and spends one extra cycle in the hold register
      checkedTransfer(1'b1, 32'h0000_0044, 1'b1, 32'hBEEF_0001, 3);
    join
    checkedTransfer(1'b0, 32'h0000_0040, 1'b0, 32'hC0FF_EE00, 2);
    checkedTransfer(1'b0, 32'h0000_0044, 1'b0, 32'hBEEF_0001, 2);
    endTest();

    beginTest("unmapped address");
    fork
      runTransfer(1'b0, 32'h3000_0000, 1'b0, '0, rdata, resp, cycles);
      begin
        // Address cycle followed by the two ERROR cycles
        for (int c = 0; c < 3; c++)
        begin
          @(negedge HCLK);
          checkTrue(!slvHsel[0] && !slvHsel[1], "a slave was selected by an unmapped access");
          if (c == 1)
            checkTrue(!mstHreadyout[0] && mstHresp[0] == hrespError,
                      "first ERROR cycle is not HRESP error with HREADYOUT low");
          if (c == 2)
            checkTrue(mstHreadyout[0] && mstHresp[0] == hrespError,
                      "second ERROR cycle is not HRESP error with HREADYOUT high");
        end
      end
    join
    checkValue("mstHresp[0]", 32'(hrespError), 32'(resp));
    checkTrue(cycles == 3, $sformatf("unmapped access took %0d cycles instead of 3", cycles));
    endTest();

    beginTest("random traffic");
    fork
      randomTraffic(1'b0);
      randomTraffic(1'b1);
    join
    endTest();

    $display("Tests: %0d passed, %0d failed, checks: %0d, errors: %0d",
             passCount, failCount, checkCount, errorCount);
    if (errorCount == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
ahbSwitchPkg.sv
ahbMasterPort.sv
ahbSlavePort.sv
ahbSwitchTop.sv
tbMemSlave.sv
tbAhbSwitch.sv

// ==== run.sh ====
#!/bin/sh
# Builds the AHB switch testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f build.f --top-module tbAhbSwitch -o simAhbSwitch

./obj_dir/simAhbSwitch | tee sim.log

if grep -q "^Finished with no errors$" sim.log
then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
